/* include/cart_macros.svh */
// Widths, magic bytes, load addresses and cycle counts of the cartridge loader
// Addresses are byte addresses in a 22-bit space, PRG low and CHR at the top half
// Magic words hold header byte 0 in their most significant byte
`ifndef CART_MACROS_SVH
`define CART_MACROS_SVH

`define CART_ADDR_W 22
`define CART_BYTE_W 8
`define HDR_BYTES 16

// Region bases
`define PRG_BASE 22'h000000
`define CHR_BASE 22'h200000
`define BIOS_BASE 22'h000010      // BIOS data after its 16 byte header
`define FDS_HDR_BASE 22'h010010   // Disk data of an image with FDS magic
`define FDS_RAW_BASE 22'h010020   // Disk data of a headerless FDS file

// Host file type codes
`define FILETYPE_BIOS 8'd2
`define FILETYPE_FDS 8'd3

// Machine held in reset this long after a download
`define DOWNLOAD_RESET_CYCLES 8'd255

// Phase of the four-phase counter that owns the memory write slot
`define MEM_SLOT_PHASE 2'd3

// "NES\x1A" and "FDS\x1A"
`define MAGIC_NES 32'h4E45531A
`define MAGIC_FDS 32'h4644531A

`endif

/* logic/cart_pkg.sv */
// Shared types of the cartridge loader
// The header union puts byte 0 in its most significant byte, so the raw view
// indexes bytes 0 to 15 in file order
`include "cart_macros.svh"

package cart_pkg;

	// Named view of the 16 byte header
	typedef struct packed {
		logic [4*`CART_BYTE_W-1:0] magic;
		logic [`CART_BYTE_W-1:0] prg_pages;   // 16 KiB units
		logic [`CART_BYTE_W-1:0] chr_pages;   // 8 KiB units, 0 means CHR RAM
		logic [`CART_BYTE_W-1:0] flags6;
		logic [`CART_BYTE_W-1:0] flags7;
		logic [`CART_BYTE_W-1:0] byte8;       // Submapper and mapper high bits on iNES 2.0
		logic [9:15][`CART_BYTE_W-1:0] tail;
	} ines_fields_t;

	typedef union packed {
		logic [0:`HDR_BYTES-1][`CART_BYTE_W-1:0] raw;
		ines_fields_t fields;
	} ines_header_u;

	// Mapper flags word as the NES core expects it
	typedef struct packed {
		logic [6:0] pad;
		logic [7:0] submapper;
		logic four_screen;
		logic has_chr_ram;
		logic mirroring;
		logic [2:0] chr_size;    // 8 KiB << code
		logic [2:0] prg_size;    // 16 KiB << code
		logic [7:0] mapper;
	} mapper_flags_t;

	// One byte write into cartridge memory
	typedef struct packed {
		logic [`CART_ADDR_W-1:0] addr;
		logic [`CART_BYTE_W-1:0] data;
	} mem_write_t;

	typedef enum logic [2:0] {
		HEADER = 3'd0,
		PRG    = 3'd1,
		CHR    = 3'd2,
		FAIL   = 3'd3,
		DISK   = 3'd4
	} loader_state_e;

endpackage

/* logic/reset_sequencer.sv */
// Holds the machine in reset until the first download, and for a fixed count after each one
// A failed load keeps the machine in reset until the next download starts
`timescale 1ns/1ps
`include "cart_macros.svh"

module reset_sequencer (
	input  logic clk,
	input  logic reset,
	input  logic download_active,
	output logic loader_reset,
	output logic machine_reset,
	input  logic loader_fail
);

	logic [7:0] reset_cnt;   // Post-download countdown
	logic hold;              // No usable image in memory yet
	logic counting;

	assign counting = (reset_cnt != 8'd0);

	always_ff @(posedge clk) begin
		if (reset) begin
			hold <= 1'b1;
			reset_cnt <= 8'd0;
		end else if (download_active) begin
			hold <= 1'b0;
			reset_cnt <= `DOWNLOAD_RESET_CYCLES;
		end else begin
			// Latch a failure so it outlives the loader's own reset
			if (loader_fail)
				hold <= 1'b1;
			if (counting)
				reset_cnt <= reset_cnt - 8'd1;
		end
	end

	// Loader is idle and cleared between downloads
	assign loader_reset = reset || (!counting && !download_active);

	assign machine_reset = reset || hold || counting || loader_fail;

endmodule

/* logic/ines_loader_fsm.sv */
// Parses the 16 byte header and steers every byte to its cartridge address
// Trainers are not supported and such images fail
// Byte strobes come at least 4 cycles apart, so the PRG to CHR hand-over sees no byte
`timescale 1ns/1ps
`include "cart_macros.svh"

module ines_loader_fsm (
	input  logic clk,
	input  logic reset,
	input  logic download_active,
	input  logic byte_valid,
	input  logic [`CART_BYTE_W-1:0] byte_data,
	input  logic [7:0] filetype,
	output logic loader_we,
	output cart_pkg::mem_write_t loader_wr,
	output cart_pkg::ines_header_u header,
	output cart_pkg::loader_state_e state,
	output logic done,
	output logic fail
);

	// Raw FDS files put their header just below the disk data
	localparam logic [`CART_ADDR_W-1:0] FDS_START =
		`FDS_RAW_BASE - `CART_ADDR_W'(`HDR_BYTES);
	localparam logic [`CART_ADDR_W-1:0] ADDR_INC = `CART_ADDR_W'(1);

	logic [3:0] ctr;                          // Header byte index
	logic [`CART_ADDR_W-1:0] wr_addr;
	logic [`CART_ADDR_W-1:0] bytes_left;      // Remaining PRG or CHR bytes
	logic [`CART_ADDR_W-1:0] start_addr;
	logic payload_phase;
	logic last_hdr_byte;

	assign start_addr = (filetype == `FILETYPE_FDS) ? FDS_START : `PRG_BASE;
	assign payload_phase = (state == cart_pkg::PRG) || (state == cart_pkg::CHR);
	assign last_hdr_byte = (ctr == 4'(`HDR_BYTES - 1));

	// Header and disk bytes always land, ROM bytes only while the count lasts
	assign loader_we = byte_valid &&
		((payload_phase && bytes_left != '0) ||
		(download_active && (state == cart_pkg::HEADER || state == cart_pkg::DISK)));

	assign loader_wr = '{addr: wr_addr, data: byte_data};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cart_pkg::HEADER;
			ctr <= 4'd0;
			wr_addr <= start_addr;   // Follows filetype until the download starts
			bytes_left <= '0;
			done <= 1'b0;
			fail <= 1'b0;
		end else begin
			case (state)
			cart_pkg::HEADER: if (byte_valid) begin
				ctr <= ctr + 4'd1;
				wr_addr <= wr_addr + ADDR_INC;
				header.raw[ctr] <= byte_data;
				if (last_hdr_byte) begin
					// Bytes 0 to 6 are already captured at this point
					if (header.fields.magic == `MAGIC_NES && !header.fields.flags6[2]) begin
						state <= cart_pkg::PRG;
						wr_addr <= `PRG_BASE;
						bytes_left <= {header.fields.prg_pages, 14'b0};
					end else if (header.fields.magic == `MAGIC_FDS) begin
						state <= cart_pkg::DISK;
						wr_addr <= `FDS_HDR_BASE;
					end else if (filetype == `FILETYPE_BIOS) begin
						state <= cart_pkg::DISK;
						wr_addr <= `BIOS_BASE;
					end else if (filetype == `FILETYPE_FDS) begin
						state <= cart_pkg::DISK;
						wr_addr <= `FDS_RAW_BASE;
					end else begin
						state <= cart_pkg::FAIL;
					end
				end
			end
			cart_pkg::PRG, cart_pkg::CHR: begin
				if (bytes_left != '0) begin
					if (byte_valid) begin
						bytes_left <= bytes_left - ADDR_INC;
						wr_addr <= wr_addr + ADDR_INC;
					end
				end else if (state == cart_pkg::PRG) begin
					state <= cart_pkg::CHR;
					wr_addr <= `CHR_BASE;
					bytes_left <= {1'b0, header.fields.chr_pages, 13'b0};
				end else begin
					done <= 1'b1;
				end
			end
			cart_pkg::FAIL: begin
				done <= 1'b1;
				fail <= 1'b1;
			end
			cart_pkg::DISK: begin
				if (download_active) begin
					if (byte_valid)
						wr_addr <= wr_addr + ADDR_INC;
				end else begin
					done <= 1'b1;
					// Fixed disk header of mapper 20 with CHR RAM and no PRG masking
					header.fields.prg_pages <= 8'hFF;
					header.fields.chr_pages <= 8'h00;
					header.fields.flags6 <= 8'h40;
					header.fields.flags7 <= 8'h10;
					header.fields.byte8 <= 8'h00;
					header.fields.tail <= '0;
				end
			end
			default: state <= cart_pkg::FAIL;
			endcase
		end
	end

	// A byte past the spent PRG count would be lost in the hand-over to CHR
	assert property (@(posedge clk) disable iff (reset)
		state == cart_pkg::PRG && bytes_left == '0 |-> !byte_valid)
		else $error("byte 0x%02h arrived after the PRG count ran out", byte_data);

endmodule

/* logic/mapper_flag_decoder.sv */
// Turns the captured header into the mapper flags word
// Tells iNES 2.0 from dirty iNES 1.0 headers, flags load while done is high
`timescale 1ns/1ps

module mapper_flag_decoder (
	input  logic clk,
	input  logic reset,
	input  cart_pkg::ines_header_u header,
	input  logic invert_mirroring,
	input  logic done,
	input  cart_pkg::loader_state_e state,
	input  logic fail,
	output cart_pkg::mapper_flags_t mapper_flags
);

	logic is_nes20;
	logic is_dirty;
	cart_pkg::mapper_flags_t next_flags;

	// Ceiling of log2 of the page count, saturating at 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd0;
		for (int i = 0; i < 7; i++) begin
			if (pages > (8'd1 << i))
				code = code + 3'd1;
		end
		return code;
	endfunction

	assign is_nes20 = (header.fields.flags7[3:2] == 2'b10);

	// Old dumpers left junk in bytes 9 to 15, bit 0 of byte 9 is the TV system
	assign is_dirty = !is_nes20 &&
		((header.fields.tail[9][7:1] != 7'd0) || (header.fields.tail[10:15] != '0));

	always_comb begin
		next_flags = '0;
		next_flags.submapper = is_nes20 ? header.fields.byte8 : 8'h00;
		next_flags.four_screen = header.fields.flags6[3];
		next_flags.has_chr_ram = (header.fields.chr_pages == 8'd0);
		next_flags.mirroring = header.fields.flags6[0] ^ invert_mirroring;
		next_flags.chr_size = size_code(header.fields.chr_pages);
		next_flags.prg_size = size_code(header.fields.prg_pages);
		// Upper nibble is junk on a dirty header
		next_flags.mapper = {is_dirty ? 4'h0 : header.fields.flags7[7:4],
			header.fields.flags6[7:4]};
	end

	always_ff @(posedge clk) begin
		if (reset)
			mapper_flags <= '0;
		else if (done)
			mapper_flags <= next_flags;
	end

	// Completion only comes from an end state, and failure only from FAIL
	assert property (@(posedge clk) disable iff (reset)
		done |-> (fail ? state == cart_pkg::FAIL
			: state inside {cart_pkg::CHR, cart_pkg::DISK}))
		else $error("done in state %s with fail=%b", state.name(), fail);

endmodule

/* logic/mem_write_stager.sv */
// Holds one loader write until the memory slot of a free-running 4 phase counter
// Only one write may be outstanding, so byte strobes need at least 4 cycles between them
`timescale 1ns/1ps
`include "cart_macros.svh"

module mem_write_stager (
	input  logic clk,
	input  logic reset,
	input  logic loader_we,
	input  cart_pkg::mem_write_t loader_wr,
	output logic mem_we,
	output cart_pkg::mem_write_t mem_wr
);

	logic [1:0] phase;
	logic pending;
	logic slot;
	cart_pkg::mem_write_t held_wr;

	assign slot = (phase == `MEM_SLOT_PHASE);

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= 2'd0;
			pending <= 1'b0;
			mem_we <= 1'b0;
		end else begin
			phase <= phase + 2'd1;
			// A write arriving in the slot itself goes straight through
			mem_we <= slot && (pending || loader_we);
			if (slot)
				pending <= 1'b0;
			else if (loader_we)
				pending <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (loader_we)
			held_wr <= loader_wr;
		if (slot)
			mem_wr <= pending ? held_wr : loader_wr;
	end

	assert property (@(posedge clk) disable iff (reset) loader_we |-> !pending)
		else $error("loader write 0x%06h arrived with one still pending", loader_wr.addr);

endmodule

/* logic/cart_loader_top.sv */
// Cartridge image loader with download reset sequencing
// byte_valid is a one cycle strobe without back-pressure, at least 4 cycles apart
`timescale 1ns/1ps
`include "cart_macros.svh"

module cart_loader_top (
	input  logic clk,
	input  logic reset,
	input  logic download_active,
	input  logic [7:0] filetype,
	input  logic byte_valid,
	input  logic [`CART_BYTE_W-1:0] byte_data,
	input  logic invert_mirroring,
	output logic mem_we,
	output cart_pkg::mem_write_t mem_wr,
	output cart_pkg::mapper_flags_t mapper_flags,
	output logic loader_done,
	output logic loader_fail,
	output logic machine_reset
);

	logic loader_reset;
	logic loader_we;
	cart_pkg::mem_write_t loader_wr;
	cart_pkg::ines_header_u header;
	cart_pkg::loader_state_e state;

	reset_sequencer u_seq (
		.clk(clk),
		.reset(reset),
		.download_active(download_active),
		.loader_reset(loader_reset),
		.machine_reset(machine_reset),
		.loader_fail(loader_fail)
	);

	ines_loader_fsm u_fsm (
		.clk(clk),
		.reset(loader_reset),
		.download_active(download_active),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.filetype(filetype),
		.loader_we(loader_we),
		.loader_wr(loader_wr),
		.header(header),
		.state(state),
		.done(loader_done),
		.fail(loader_fail)
	);

	// Flags survive the loader reset that follows each download
	mapper_flag_decoder u_dec (
		.clk(clk),
		.reset(reset),
		.header(header),
		.invert_mirroring(invert_mirroring),
		.done(loader_done),
		.state(state),
		.fail(loader_fail),
		.mapper_flags(mapper_flags)
	);

	mem_write_stager u_stage (
		.clk(clk),
		.reset(reset),
		.loader_we(loader_we),
		.loader_wr(loader_wr),
		.mem_we(mem_we),
		.mem_wr(mem_wr)
	);

endmodule

/* sim/tb_cart_loader.sv */
// Testbench of the cartridge loader, run from the project root
// Images and expected results come from sim/loader_patterns.txt, payload bytes from $random
// Byte strobes are 6 cycles apart, mapper flags of a failed load are not compared
`timescale 1ns/1ps
`include "cart_macros.svh"

module tb_cart_loader;

	typedef struct packed {
		logic done;
		logic fail;
		logic machine_reset;
	} status_t;

	// One test image as read from the pattern file
	typedef struct packed {
		logic [7:0] filetype;
		logic invert;
		cart_pkg::ines_header_u header;
		logic [31:0] length;             // Payload bytes after the header
		cart_pkg::mapper_flags_t flags;
		logic fail;
		logic done;
	} pattern_t;

	logic clk;
	logic reset;
	logic download_active;
	logic [7:0] filetype;
	logic byte_valid;
	logic [7:0] byte_data;
	logic invert_mirroring;
	logic mem_we;
	cart_pkg::mem_write_t mem_wr;
	cart_pkg::mapper_flags_t mapper_flags;
	logic loader_done;
	logic loader_fail;
	logic machine_reset;

	pattern_t pats[$];
	cart_pkg::mem_write_t expected_q[$];
	integer seed;
	int mismatches;
	int other_errors;
	int watch_limit;   // Watchdog length in cycles

	cart_loader_top dut0 (
		.clk(clk),
		.reset(reset),
		.download_active(download_active),
		.filetype(filetype),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.invert_mirroring(invert_mirroring),
		.mem_we(mem_we),
		.mem_wr(mem_wr),
		.mapper_flags(mapper_flags),
		.loader_done(loader_done),
		.loader_fail(loader_fail),
		.machine_reset(machine_reset)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Address of image byte k, header included, or -1 where no write is due
	function automatic int expected_addr(input pattern_t p, input int k);
		int prg_bytes;
		int chr_bytes;
		int start;
		int n;
		prg_bytes = int'(p.header.fields.prg_pages) * 16384;
		chr_bytes = int'(p.header.fields.chr_pages) * 8192;
		start = (p.filetype == `FILETYPE_FDS) ? int'(`FDS_RAW_BASE) - `HDR_BYTES : 0;
		if (k < `HDR_BYTES)
			return start + k;
		n = k - `HDR_BYTES;
		if (p.header.fields.magic == `MAGIC_NES && !p.header.fields.flags6[2]) begin
			if (n < prg_bytes)
				return int'(`PRG_BASE) + n;
			if (n < prg_bytes + chr_bytes)
				return int'(`CHR_BASE) + n - prg_bytes;
			return -1;   // Past the ROM end
		end
		if (p.header.fields.magic == `MAGIC_FDS)
			return int'(`FDS_HDR_BASE) + n;
		if (p.filetype == `FILETYPE_BIOS)
			return int'(`BIOS_BASE) + n;
		if (p.filetype == `FILETYPE_FDS)
			return int'(`FDS_RAW_BASE) + n;
		return -1;
	endfunction

	function automatic status_t sample_status();
		return {loader_done, loader_fail, machine_reset};
	endfunction

	task automatic check_mem_write(input cart_pkg::mem_write_t got);
		cart_pkg::mem_write_t exp;
		if (expected_q.size() == 0) begin
			$display("unexpected memory write of %02h to %06h at %0t ns",
				got.data, got.addr, $time);
			other_errors++;
		end else begin
			exp = expected_q.pop_front();
			if (got !== exp) begin
				$display("mismatch at %0t ns: write %06h <= %02h, expected %06h <= %02h",
					$time, got.addr, got.data, exp.addr, exp.data);
				mismatches++;
			end
		end
	endtask

	task automatic check_flags(input cart_pkg::mapper_flags_t got,
		input cart_pkg::mapper_flags_t exp, input int idx);
		if (got !== exp) begin
			$display("mismatch at %0t ns: image %0d mapper flags %08h, expected %08h",
				$time, idx, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_status(input status_t got, input status_t exp, input string when);
		if (got !== exp) begin
			$display("mismatch at %0t ns: done/fail/machine_reset %b%b%b %s, expected %b%b%b",
				$time, got.done, got.fail, got.machine_reset, when,
				exp.done, exp.fail, exp.machine_reset);
			mismatches++;
		end
	endtask

	task automatic strobe_byte(input logic [7:0] d);
		@(negedge clk);
		byte_valid = 1'b1;
		byte_data = d;
		@(negedge clk);
		byte_valid = 1'b0;
		repeat (4) @(negedge clk);
	endtask

	task automatic run_image(input pattern_t p, input int idx);
		int addr;
		int waited;
		logic [7:0] d;
		cart_pkg::mem_write_t w;
		@(negedge clk);
		filetype = p.filetype;   // Settles the start address before the download
		invert_mirroring = p.invert;
		@(negedge clk);
		download_active = 1'b1;
		for (int k = 0; k < `HDR_BYTES + int'(p.length); k++) begin
			if (k < `HDR_BYTES)
				d = p.header.raw[4'(k)];
			else
				d = 8'($random(seed));
			addr = expected_addr(p, k);
			if (addr >= 0) begin
				w.addr = 22'(addr);
				w.data = d;
				expected_q.push_back(w);
			end
			strobe_byte(d);
		end
		download_active = 1'b0;
		waited = 0;
		while (p.done && !loader_done && waited < 8) begin
			@(negedge clk);
			waited++;
		end
		check_status(sample_status(), {p.done, p.fail, 1'b1}, "after the download");
		if (expected_q.size() != 0) begin
			$display("image %0d: %0d expected memory writes never came out",
				idx, expected_q.size());
			other_errors++;
			expected_q.delete();
		end
		repeat (2) @(negedge clk);   // Flags load the cycle after done
		waited += 2;
		if (!p.fail)
			check_flags(mapper_flags, p.flags, idx);
		repeat (200 - waited) @(negedge clk);
		check_status(sample_status(), {p.done, p.fail, 1'b1}, "in the post-download reset");
		repeat (int'(`DOWNLOAD_RESET_CYCLES) + 11 - 200) @(negedge clk);
		check_status(sample_status(), {1'b0, 1'b0, p.fail}, "after the post-download reset");
	endtask

	always @(negedge clk) begin
		if (!reset && mem_we)
			check_mem_write(mem_wr);
	end

	initial begin
		wait (watch_limit != 0);
		repeat (watch_limit) @(posedge clk);
		$display("watchdog expired after %0d cycles, the loader test did not finish", watch_limit);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		string line;
		int fd;
		int n;
		int limit;
		logic [127:0] hdr;
		logic [31:0] ft, inv, len, flags, fl, dn;
		pattern_t p;
		seed = 32'hf60d5bdf;
		reset = 1'b1;
		download_active = 1'b0;
		filetype = 8'd0;
		byte_valid = 1'b0;
		byte_data = 8'd0;
		invert_mirroring = 1'b0;
		mismatches = 0;
		other_errors = 0;
		watch_limit = 0;
		fd = $fopen("sim/loader_patterns.txt", "r");
		if (fd == 0) begin
			$display("cannot open sim/loader_patterns.txt, run from the project root");
			other_errors++;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %d %h %h %h",
						ft, inv, hdr, len, flags, fl, dn);
					if (n == 7) begin
						p.filetype = ft[7:0];
						p.invert = inv[0];
						p.header = hdr;
						p.length = len;
						p.flags = flags;
						p.fail = fl[0];
						p.done = dn[0];
						pats.push_back(p);
					end
				end
			end
			$fclose(fd);
			if (pats.size() == 0) begin
				$display("the pattern file holds no test images");
				other_errors++;
			end
		end
		limit = 2000;
		foreach (pats[i])
			limit += (int'(pats[i].length) + `HDR_BYTES) * 8 + 300;
		watch_limit = limit;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		repeat (20) @(negedge clk);
		check_status(sample_status(), 3'b001, "before the first download");
		foreach (pats[i])
			run_image(pats[i], i);
		$display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
		if (mismatches + other_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* sim/loader_patterns.txt */
# filetype invert header(16 bytes, byte 0 first) payload_bytes expected_flags expected_fail expected_done
# All columns in hex except payload_bytes, which is decimal
01 1 4E45531A010130200000000000000000 24576 00004023 0 1
01 0 4E45531B010100000000000000000000 8 00000000 1 1
01 0 4E45531A032811482500070000000000 376832 004A7241 0 1
01 0 4E45531A010048700000004469736B44 16384 00018004 0 1
01 0 4E45531A010104000000000000000000 8 00000000 1 1
01 0 4644531A020000000000000000000000 40 00008714 0 1
02 1 00112233445566778899AABBCCDDEEFF 48 0000C714 0 1
03 0 012A4E494E54454E444F2D4856432A01 40 00008714 0 1

/* vlog.f */
+incdir+include
logic/cart_pkg.sv
logic/reset_sequencer.sv
logic/ines_loader_fsm.sv
logic/mapper_flag_decoder.sv
logic/mem_write_stager.sv
logic/cart_loader_top.sv
sim/tb_cart_loader.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_cart_loader -f vlog.f -o tb_cart_loader &&
./obj_dir/tb_cart_loader | tee /dev/stderr | grep -q "Result: PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
